// File: verification/rom_load_patterns.mem
// Columns: header bytes 0-3, 4-7, 8-11, 12-15, invert_mirroring, expected mapper_flags, error
// Header words put the lowest byte number in the top bits
// iNES 1.0, 1 PRG, 1 CHR, mapper 21h, vertical mirroring
4E45531A 01011120 00000000 00000000 0 00004021 0
// Bad magic, last byte 1Bh
4E45531B 01010000 00000000 00000000 0 00000000 1
// Trainer bit in flags6
4E45531A 01010400 00000000 00000000 0 00000000 1
// 2 PRG, no CHR, four-screen; CHR RAM and PRG bucket 1
4E45531A 02000800 00000000 00000000 0 00018100 0
// 3 PRG, 5 CHR; buckets 2 and 3
4E45531A 03050000 00000000 00000000 0 00001A00 0
// Dirty legacy header, flags7 nibble 3 dropped
4E45531A 01011030 00004400 00000000 0 00000001 0
// NES 2.0, mapper high nibble 5, mapper 34h, mirroring inverted to 0
4E45531A 01024138 05000000 07000000 1 000A0834 0
// Mirroring inverted from 0 to 1, CHR RAM
4E45531A 01000000 00000000 00000000 1 0000C000 0

// File: list.f
+incdir+source
source/rom_loader_pkg.sv
source/ines_header_parser.sv
source/load_sequencer.sv
source/rom_addr_counter.sv
source/axil_write_master.sv
source/rom_loader_top.sv
verification/rom_loader_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := rom_loader_tb
LINT_TOP   := rom_loader_top
FILE_LIST  := list.f
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "No result line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/rom_loader_tb.sv
//********************
// Reads records from verification/rom_load_patterns.mem, so run from the project root
//********************
`default_nettype none

`include "rom_loader_defs.svh"

module rom_loader_tb;

  localparam int REC_WORDS    = 7; // 4 header words, invert, flags, error
  localparam int MAX_RECS     = 16;
  localparam int BYTE_TIMEOUT = 200;
  localparam int DONE_TIMEOUT = 2000;
  localparam int DRIVE_DLY    = 1;
  localparam int PRG_PAGE     = 16384; // 16 KB per PRG page
  localparam int CHR_PAGE     = 8192;  // 8 KB per CHR page

  localparam logic [31:0] CHR_BASE = 32'h0020_0000; // CHR region at 2 MB

  logic                          clk = 1'b0;
  logic                          reset;
  logic [7:0]                    in_data;
  logic                          in_valid;
  logic                          in_ready;
  logic                          invert_mirroring;
  logic                          awvalid;
  rom_loader_pkg::axil_aw_t      aw;
  logic                          awready;
  logic                          wvalid;
  rom_loader_pkg::axil_w_t       w;
  logic                          wready;
  logic                          bvalid;
  logic [1:0]                    bresp;
  logic                          bready;
  rom_loader_pkg::mapper_flags_t mapper_flags;
  logic                          done;
  logic                          error;

  logic [31:0] recs [REC_WORDS*MAX_RECS];
  logic [7:0]  mem [logic [31:0]]; // Sparse byte memory behind the slave
  integer      seed = 32'h53cd;
  int          num_recs;
  int          wr_count;   // AXI writes in the current record
  int          checks;
  int          mismatches;
  int          failures;   // Timeouts, lost or doubled bytes
  logic        stop_rec;
  logic        timed_out;

  // Slave side bookkeeping
  logic                    rst_seen;
  logic                    aw_fire;
  logic                    w_fire;
  logic                    b_fire;
  logic                    aw_have;
  logic                    w_have;
  logic [31:0]             aw_addr;
  rom_loader_pkg::axil_w_t w_beat;

  rom_loader_top dut_i (
    .clk, .reset, .in_data, .in_valid, .in_ready, .invert_mirroring,
    .awvalid, .aw, .awready, .wvalid, .w, .wready, .bvalid, .bresp, .bready,
    .mapper_flags, .done, .error
  );

  always #4 clk = ~clk;

  // Store each strobed lane, flag any byte written twice
  task automatic store_write(input logic [31:0] addr, input rom_loader_pkg::axil_w_t beat);
    logic [31:0]             a;
    rom_loader_pkg::axil_w_t exp_beat;
    wr_count++;
    exp_beat.wstrb = '0;
    exp_beat.wstrb[addr[1:0]] = 1'b1; // One lane per byte address
    exp_beat.wdata = {4{beat.wdata[8*addr[1:0] +: 8]}}; // Same byte on all lanes
    check_beat(addr, beat, exp_beat);
    for (int i = 0; i < 4; i++) begin
      if (beat.wstrb[i]) begin
        a = {addr[31:2], 2'(i)};
        if (mem.exists(a)) begin
          $display("Byte at offset %06h written twice at t=%0t", a, $time);
          failures++;
        end
        mem[a] = beat.wdata[8*i +: 8];
      end
    end
  endtask

  // AXI4-Lite slave; handshakes seen mid-cycle, outputs move just after the edge
  always begin
    @(negedge clk);
    rst_seen = reset;
    aw_fire  = awvalid && awready;
    w_fire   = wvalid && wready;
    b_fire   = bvalid && bready;
    if (aw_fire) aw_addr = aw.awaddr;
    if (w_fire)  w_beat  = w;
    @(posedge clk);
    #DRIVE_DLY;
    if (rst_seen) begin
      aw_have = 1'b0;
      w_have  = 1'b0;
      bvalid  = 1'b0;
    end else begin
      aw_have = aw_have || aw_fire;
      w_have  = w_have || w_fire;
      if (b_fire) bvalid = 1'b0;
      if (aw_have && w_have && !bvalid) begin
        store_write(aw_addr, w_beat);
        aw_have = 1'b0;
        w_have  = 1'b0;
        bvalid  = 1'b1; // Always OKAY
      end
    end
    awready = (($random(seed) & 32'd3) != 32'd0); // Stall about a quarter of cycles
    wready  = (($random(seed) & 32'd3) != 32'd0);
  end

  task automatic check_flags(input rom_loader_pkg::mapper_flags_t got,
                             input rom_loader_pkg::mapper_flags_t exp);
    checks++;
    if (got !== exp) begin
      $display("ERROR t=%0t mapper_flags got %08h exp %08h", $time, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_byte(input logic [31:0] addr, input logic [7:0] got,
                            input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      $display("ERROR t=%0t mem[%06h] got %02h exp %02h", $time, addr, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_beat(input logic [31:0] addr, input rom_loader_pkg::axil_w_t got,
                            input rom_loader_pkg::axil_w_t exp);
    checks++;
    if (got !== exp) begin
      $display("ERROR t=%0t w at %06h got %09h exp %09h", $time, addr, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_status(input logic got_done, input logic got_error,
                              input logic exp_done, input logic exp_error);
    checks++;
    if (got_done !== exp_done) begin
      $display("ERROR t=%0t done got %b exp %b", $time, got_done, exp_done);
      mismatches++;
    end
    if (got_error !== exp_error) begin
      $display("ERROR t=%0t error got %b exp %b", $time, got_error, exp_error);
      mismatches++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      $display("ERROR t=%0t %s got %0d exp %0d", $time, name, got, exp);
      mismatches++;
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #DRIVE_DLY;
    reset = 1'b1;
    repeat (4) @(posedge clk);
    #DRIVE_DLY;
    reset = 1'b0;
  endtask

  // Hold one byte until the DUT takes it; entered and left just after an edge
  task automatic send_byte(input logic [7:0] data);
    int waited;
    waited   = 0;
    in_data  = data;
    in_valid = 1'b1;
    @(negedge clk);
    while (!in_ready && !done && waited < BYTE_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!in_ready) begin
      if (done) begin
        $display("Load ended at t=%0t before byte %02h was accepted", $time, data);
      end else begin
        $display("Timeout at t=%0t, in_ready stayed low for byte %02h", $time, data);
        timed_out = 1'b1;
      end
      failures++;
      stop_rec = 1'b1;
    end
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic wait_done();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!done && waited < DONE_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!done) begin
      $display("Timeout at t=%0t waiting for done", $time);
      failures++;
      timed_out = 1'b1;
      stop_rec  = 1'b1;
    end
  endtask

  // Offer a byte after a failed load, it must never be taken
  task automatic probe_in_ready_low();
    @(posedge clk);
    #DRIVE_DLY;
    in_valid = 1'b1;
    repeat (8) begin
      @(negedge clk);
      if (in_ready) begin
        $display("in_ready went high after the load failed, t=%0t", $time);
        failures++;
      end
    end
    @(posedge clk);
    #DRIVE_DLY;
    in_valid = 1'b0;
  endtask

  task automatic verify_region(input logic [31:0] base, input int len, input logic [7:0] rec_no);
    logic [31:0] a;
    for (int i = 0; i < len; i++) begin
      a = base + 32'(i);
      if (!mem.exists(a)) begin
        $display("No write seen at offset %06h, t=%0t", a, $time);
        failures++;
        break; // Rest of the region would repeat the same story
      end
      check_byte(a, mem[a], i[7:0] ^ rec_no);
    end
  endtask

  task automatic run_record(input int r);
    logic [127:0]                  hdr;
    rom_loader_pkg::mapper_flags_t exp_flags;
    logic                          exp_err;
    logic [7:0]                    rec_no;
    int                            prg_len;
    int                            chr_len;
    hdr       = {recs[r*REC_WORDS], recs[r*REC_WORDS+1], recs[r*REC_WORDS+2],
                 recs[r*REC_WORDS+3]};
    exp_flags = recs[r*REC_WORDS+5];
    exp_err   = recs[r*REC_WORDS+6][0];
    rec_no    = r[7:0];
    prg_len   = int'(hdr[95:88]) * PRG_PAGE; // Byte 4
    chr_len   = int'(hdr[87:80]) * CHR_PAGE; // Byte 5
    mem.delete();
    wr_count = 0;
    stop_rec = 1'b0;
    apply_reset();
    invert_mirroring = recs[r*REC_WORDS+4][0];
    @(negedge clk);
    check_status(done, error, 1'b0, 1'b0);
    @(posedge clk);
    #DRIVE_DLY;
    for (int k = 0; k < `ROM_HDR_BYTES && !stop_rec; k++) send_byte(hdr[127-8*k -: 8]);
    if (!exp_err) begin
      for (int i = 0; i < prg_len && !stop_rec; i++) send_byte(i[7:0] ^ rec_no);
      for (int i = 0; i < chr_len && !stop_rec; i++) send_byte(i[7:0] ^ rec_no);
    end
    in_valid = 1'b0;
    if (!stop_rec) wait_done();
    if (stop_rec) return;
    check_status(done, error, 1'b1, exp_err);
    if (exp_err) begin
      check_count("AXI write count", wr_count, 0);
      probe_in_ready_low();
    end else begin
      check_flags(mapper_flags, exp_flags);
      verify_region(32'h0, prg_len, rec_no);
      verify_region(CHR_BASE, chr_len, rec_no);
      if (chr_len == 0 && mem.exists(CHR_BASE)) begin
        $display("CHR RAM image wrote at the CHR base, t=%0t", $time);
        failures++;
      end
      check_count("AXI write count", wr_count, prg_len + chr_len);
      check_count("stored byte count", mem.num(), prg_len + chr_len);
    end
  endtask

  initial begin
    reset            = 1'b1;
    in_data          = 8'h00;
    in_valid         = 1'b0;
    invert_mirroring = 1'b0;
    awready          = 1'b0;
    wready           = 1'b0;
    bvalid           = 1'b0;
    bresp            = 2'b00;
    aw_have          = 1'b0;
    w_have           = 1'b0;
    checks           = 0;
    mismatches       = 0;
    failures         = 0;
    timed_out        = 1'b0;
    for (int i = 0; i < REC_WORDS*MAX_RECS; i++) recs[i] = '1; // All ones marks no record
    $readmemh("verification/rom_load_patterns.mem", recs);
    num_recs = 0;
    while (num_recs < MAX_RECS && recs[num_recs*REC_WORDS] != '1) num_recs++;
    if (num_recs == 0) begin
      $display("No records found in the pattern file");
      failures++;
    end
    for (int r = 0; r < num_recs && !timed_out; r++) run_record(r);
    $display("Summary: %0d records, %0d checks, %0d mismatches, %0d other failures",
             num_recs, checks, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/rom_loader_top.sv
//********************
// mapper_flags only meaningful while done is high and error low
//********************
`default_nettype none

`include "rom_loader_defs.svh"

module rom_loader_top (
  input  wire                           clk,
  input  wire                           reset,
  input  wire  [7:0]                    in_data,
  input  wire                           in_valid,
  output logic                          in_ready,
  input  wire                           invert_mirroring,
  output logic                          awvalid,
  output rom_loader_pkg::axil_aw_t      aw,
  input  wire                           awready,
  output logic                          wvalid,
  output rom_loader_pkg::axil_w_t       w,
  input  wire                           wready,
  input  wire                           bvalid,
  input  wire  [1:0]                    bresp,
  output logic                          bready,
  output rom_loader_pkg::mapper_flags_t mapper_flags,
  output logic                          done,
  output logic                          error
);

  logic                     hdr_wr_en;
  logic [3:0]               hdr_index;
  logic                     hdr_ok;
  logic [7:0]               prg_pages;
  logic [7:0]               chr_pages;
  logic                     region_load;
  logic                     region_sel;
  logic                     bytes_left_zero;
  logic [`ROM_OFS_W-1:0]    offset;
  logic                     req_valid;
  logic                     req_ready;
  logic                     wr_error;
  rom_loader_pkg::mem_req_t req;

  // Offset from the counter, byte straight from the host
  assign req.offset = offset;
  assign req.data   = in_data;

  load_sequencer seq_i (
    .clk, .reset, .in_valid, .in_ready, .hdr_wr_en, .hdr_index, .hdr_ok,
    .region_load, .region_sel, .bytes_left_zero, .req_valid, .req_ready,
    .wr_error, .phase(), .done, .error // Phase left for debug probing
  );

  ines_header_parser parser_i (
    .clk, .reset, .in_data, .hdr_wr_en, .hdr_index, .invert_mirroring,
    .hdr_ok, .prg_pages, .chr_pages, .flags(mapper_flags)
  );

  rom_addr_counter cnt_i (
    .clk, .reset, .region_load, .region_sel, .prg_pages, .chr_pages,
    .advance(req_valid), .offset, .bytes_left_zero // Each accepted byte steps once
  );

  axil_write_master wm_i (
    .clk, .reset, .req_valid, .req, .req_ready, .wr_error,
    .awvalid, .aw, .awready, .wvalid, .w, .wready, .bvalid, .bresp, .bready
  );

endmodule

`default_nettype wire

// File: source/axil_write_master.sv
//********************
// Single outstanding write; bready only after both AW and W have been accepted
//********************
`default_nettype none

`include "rom_loader_defs.svh"

module axil_write_master (
  input  wire                           clk,
  input  wire                           reset,
  input  wire                           req_valid,
  input  wire rom_loader_pkg::mem_req_t req,
  output logic                          req_ready,
  output logic                          wr_error,
  output logic                          awvalid,
  output rom_loader_pkg::axil_aw_t      aw,
  input  wire                           awready,
  output logic                          wvalid,
  output rom_loader_pkg::axil_w_t       w,
  input  wire                           wready,
  input  wire                           bvalid,
  input  wire  [1:0]                    bresp,
  output logic                          bready
);

  localparam logic [1:0] RESP_OKAY = 2'b00;

  rom_loader_pkg::axil_aw_t aw_q;
  rom_loader_pkg::axil_w_t  w_q;

  logic busy_q;    // Request latched, response not yet back
  logic aw_pend_q;
  logic w_pend_q;
  logic accept;

  assign req_ready = !busy_q;
  assign accept    = req_valid && req_ready;

  assign awvalid = aw_pend_q;
  assign aw      = aw_q;
  assign wvalid  = w_pend_q;
  assign w       = w_q;
  assign bready  = busy_q && !aw_pend_q && !w_pend_q;

  // Slave error or decode error ends the load
  assign wr_error = bvalid && bready && (bresp != RESP_OKAY);

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q    <= 1'b0;
      aw_pend_q <= 1'b0;
      w_pend_q  <= 1'b0;
    end else if (accept) begin
      busy_q    <= 1'b1;
      aw_pend_q <= 1'b1; // AW and W go up together
      w_pend_q  <= 1'b1;
    end else begin
      if (awvalid && awready) aw_pend_q <= 1'b0; // Channels retire independently
      if (wvalid && wready)   w_pend_q  <= 1'b0;
      if (bvalid && bready)   busy_q    <= 1'b0;
    end
  end

  // Byte on every lane, strobe picks the one that counts
  always_ff @(posedge clk) begin
    if (accept) begin
      aw_q.awaddr <= `AXIL_ADDR_W'(req.offset);
      aw_q.awprot <= 3'b000; // Unprivileged, secure, data
      w_q.wdata   <= {(`AXIL_DATA_W/8){req.data}};
      w_q.wstrb   <= 4'b0001 << req.offset[1:0];
    end
  end

  aw_held: assert property (@(posedge clk) disable iff (reset)
    awvalid && !awready |=> awvalid && $stable(aw));

  // Sequencer side must respect the single write in flight
  no_req_while_busy: assert property (@(posedge clk) disable iff (reset)
    busy_q |-> !req_valid);

endmodule

`default_nettype wire

// File: source/rom_addr_counter.sv
//********************
// Page counts above 255 are not representable; PRG beyond 2 MB overlaps CHR
//********************
`default_nettype none

`include "rom_loader_defs.svh"

module rom_addr_counter (
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         region_load,
  input  wire                         region_sel,  // 0 PRG, 1 CHR
  input  wire  [7:0]                  prg_pages,
  input  wire  [7:0]                  chr_pages,
  input  wire                         advance,
  output logic [`ROM_OFS_W-1:0]       offset,
  output logic                        bytes_left_zero
);

  logic [`ROM_OFS_W-1:0] offset_q;
  logic [`ROM_OFS_W-1:0] left_q;
  logic [`ROM_OFS_W-1:0] prg_bytes;
  logic [`ROM_OFS_W-1:0] chr_bytes;

  // Page count to byte count
  assign prg_bytes = `ROM_OFS_W'(prg_pages) << `ROM_PRG_SHIFT;
  assign chr_bytes = `ROM_OFS_W'(chr_pages) << `ROM_CHR_SHIFT;

  always_ff @(posedge clk) begin
    if (reset) begin
      offset_q <= '0;
      left_q   <= '0;
    end else if (region_load) begin
      if (region_sel) begin
        offset_q <= `ROM_CHR_BASE;
        left_q   <= chr_bytes;
      end else begin
        offset_q <= '0;
        left_q   <= prg_bytes;
      end
    end else if (advance) begin
      offset_q <= offset_q + 1'b1; // Next byte address
      left_q   <= left_q - 1'b1;
    end
  end

  assign offset          = offset_q;
  assign bytes_left_zero = (left_q == '0);

  // Sequencer must stop taking bytes once the region is used up
  no_advance_past_end: assert property (@(posedge clk) disable iff (reset)
    advance |-> !bytes_left_zero);

endmodule

`default_nettype wire

// File: source/load_sequencer.sv
//********************
// One write in flight; payload bytes are only taken while the write master is idle
//********************
`default_nettype none

`include "rom_loader_defs.svh"

module load_sequencer (
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         in_valid,
  output logic                        in_ready,
  output logic                        hdr_wr_en,
  output logic [3:0]                  hdr_index,
  input  wire                         hdr_ok,
  output logic                        region_load,
  output logic                        region_sel,
  input  wire                         bytes_left_zero,
  output logic                        req_valid,
  input  wire                         req_ready,
  input  wire                         wr_error,
  output rom_loader_pkg::load_phase_e phase,
  output logic                        done,
  output logic                        error
);

  localparam logic [3:0] HDR_LAST = 4'(`ROM_HDR_BYTES - 1);

  rom_loader_pkg::load_phase_e phase_q;

  logic [3:0] hdr_cnt_q;
  logic       decide_q;  // Cycle after the last header byte
  logic       started_q; // Holds in_ready low through reset
  logic       in_header;
  logic       in_payload;
  logic       take;
  logic       region_empty;

  assign in_header  = (phase_q == rom_loader_pkg::HEADER);
  assign in_payload = (phase_q == rom_loader_pkg::PRG) || (phase_q == rom_loader_pkg::CHR);

  // Empty and last response back
  assign region_empty = bytes_left_zero && req_ready;

  always_comb begin
    if (in_header) in_ready = started_q && !decide_q;
    else           in_ready = in_payload && req_ready && !bytes_left_zero;
  end

  assign take      = in_valid && in_ready;
  assign hdr_wr_en = take && in_header;
  assign hdr_index = hdr_cnt_q;
  assign req_valid = take && in_payload; // Master is idle whenever this is high

  // PRG load at the decision, CHR load when PRG runs dry
  assign region_sel  = (phase_q == rom_loader_pkg::PRG);
  assign region_load = (decide_q && hdr_ok) ||
                       ((phase_q == rom_loader_pkg::PRG) && region_empty);

  assign phase = phase_q;
  assign done  = (phase_q == rom_loader_pkg::DONE) || (phase_q == rom_loader_pkg::FAIL);
  assign error = (phase_q == rom_loader_pkg::FAIL);

  always_ff @(posedge clk) begin
    if (reset) begin
      phase_q   <= rom_loader_pkg::HEADER;
      hdr_cnt_q <= '0;
      decide_q  <= 1'b0;
      started_q <= 1'b0;
    end else begin
      started_q <= 1'b1;
      case (phase_q)
        rom_loader_pkg::HEADER: begin
          if (decide_q) begin
            decide_q <= 1'b0;
            if (hdr_ok) phase_q <= rom_loader_pkg::PRG;
            else        phase_q <= rom_loader_pkg::FAIL;
          end else if (take) begin
            hdr_cnt_q <= hdr_cnt_q + 4'd1;
            if (hdr_cnt_q == HDR_LAST) decide_q <= 1'b1;
          end
        end
        rom_loader_pkg::PRG: begin
          if (wr_error)          phase_q <= rom_loader_pkg::FAIL;
          else if (region_empty) phase_q <= rom_loader_pkg::CHR;
        end
        rom_loader_pkg::CHR: begin
          if (wr_error)          phase_q <= rom_loader_pkg::FAIL;
          else if (region_empty) phase_q <= rom_loader_pkg::DONE;
        end
        default: ; // DONE and FAIL hold until reset
      endcase
    end
  end

  // Load only ends once the write master is idle again
  idle_at_end: assert property (@(posedge clk) disable iff (reset)
    done |-> req_ready);

endmodule

`default_nettype wire

// File: source/ines_header_parser.sv
//********************
// Outputs are combinational from the stored header; meaningful once all 16 bytes are in
//********************
`default_nettype none

`include "rom_loader_defs.svh"

module ines_header_parser (
  input  wire                          clk,
  input  wire                          reset,
  input  wire  [7:0]                   in_data,
  input  wire                          hdr_wr_en,
  input  wire  [3:0]                   hdr_index,
  input  wire                          invert_mirroring,
  output logic                         hdr_ok,
  output logic [7:0]                   prg_pages,
  output logic [7:0]                   chr_pages,
  output rom_loader_pkg::mapper_flags_t flags
);

  rom_loader_pkg::ines_hdr_t hdr_q;

  logic magic_ok;
  logic has_trainer;
  logic is_nes20;
  logic is_dirty;

  // log2 bucket of a page count, 7 covers everything above 64
  function automatic logic [2:0] size_bucket(input logic [7:0] pages);
    logic [2:0] bucket;
    if (pages <= 8'd1)       bucket = 3'd0;
    else if (pages <= 8'd2)  bucket = 3'd1;
    else if (pages <= 8'd4)  bucket = 3'd2;
    else if (pages <= 8'd8)  bucket = 3'd3;
    else if (pages <= 8'd16) bucket = 3'd4;
    else if (pages <= 8'd32) bucket = 3'd5;
    else if (pages <= 8'd64) bucket = 3'd6;
    else                     bucket = 3'd7;
    return bucket;
  endfunction

  // Header capture, byte 0 lands in the top bits
  always_ff @(posedge clk) begin
    if (reset) begin
      hdr_q <= '0; // Partial header then reads as bad magic
    end else if (hdr_wr_en) begin
      hdr_q[8*(15-hdr_index) +: 8] <= in_data;
    end
  end

  assign magic_ok    = (hdr_q.magic == {`ROM_MAGIC_0, `ROM_MAGIC_1, `ROM_MAGIC_2, `ROM_MAGIC_3});
  assign has_trainer = hdr_q.flags6[2]; // Trainer images not supported
  assign hdr_ok      = magic_ok && !has_trainer;

  assign prg_pages = hdr_q.prg_pages;
  assign chr_pages = hdr_q.chr_pages;

  // NES 2.0 marker in flags7 bits 3..2
  assign is_nes20 = (hdr_q.flags7[3:2] == 2'b10);

  // Old dumps put junk in bytes 8..15; then flags7 nibble is untrustworthy
  assign is_dirty = !is_nes20 && (hdr_q.tail.legacy != '0);

  always_comb begin
    flags             = '0;
    flags.mapper_hi   = is_nes20 ? hdr_q.tail.nes20.mapper_hi : 4'h0;
    flags.four_screen = hdr_q.flags6[3];
    flags.chr_ram     = (hdr_q.chr_pages == 8'd0);
    flags.mirroring   = hdr_q.flags6[0] ^ invert_mirroring; // User override
    flags.chr_size    = size_bucket(hdr_q.chr_pages);
    flags.prg_size    = size_bucket(hdr_q.prg_pages);
    flags.mapper[7:4] = is_dirty ? 4'h0 : hdr_q.flags7[7:4];
    flags.mapper[3:0] = hdr_q.flags6[7:4];
  end

endmodule

`default_nettype wire

// File: source/rom_loader_pkg.sv
//********************
// Types shared by the loader; header struct is ordered with byte 0 in the top bits
//********************
`default_nettype none

`include "rom_loader_defs.svh"

package rom_loader_pkg;

  // Bytes 8..15 in NES 2.0 form
  typedef struct packed {
    logic [3:0]  submapper;    // Byte 8 high nibble
    logic [3:0]  mapper_hi;    // Byte 8 low nibble, mapper bits 11..8
    logic [3:0]  chr_size_ext; // Byte 9 high nibble
    logic [3:0]  prg_size_ext; // Byte 9 low nibble
    logic [47:0] rest;         // Bytes 10..15, not decoded here
  } nes20_ext_t;

  // Same 64 bits read two ways
  typedef union packed {
    nes20_ext_t      nes20;
    logic [7:0][7:0] legacy; // Index 7 is header byte 8
  } ines_tail_u;

  typedef struct packed {
    logic [31:0] magic;     // Bytes 0..3
    logic [7:0]  prg_pages; // Byte 4, 16 KB units
    logic [7:0]  chr_pages; // Byte 5, 8 KB units, 0 means CHR RAM
    logic [7:0]  flags6;
    logic [7:0]  flags7;
    ines_tail_u  tail;      // Bytes 8..15
  } ines_hdr_t;

  // Flags word handed to the console core
  typedef struct packed {
    logic [10:0] reserved;    // Always zero
    logic [3:0]  mapper_hi;   // NES 2.0 only
    logic        four_screen;
    logic        chr_ram;
    logic        mirroring;
    logic [2:0]  chr_size;    // log2 bucket of CHR pages
    logic [2:0]  prg_size;    // log2 bucket of PRG pages
    logic [7:0]  mapper;
  } mapper_flags_t;

  typedef enum logic [2:0] {
    HEADER,
    PRG,
    CHR,
    DONE,
    FAIL
  } load_phase_e;

  typedef struct packed {
    logic [`AXIL_ADDR_W-1:0] awaddr;
    logic [2:0]              awprot;
  } axil_aw_t;

  typedef struct packed {
    logic [`AXIL_DATA_W-1:0]   wdata;
    logic [`AXIL_DATA_W/8-1:0] wstrb;
  } axil_w_t;

  // One payload byte and where it goes
  typedef struct packed {
    logic [`ROM_OFS_W-1:0] offset;
    logic [7:0]            data;
  } mem_req_t;

endpackage

`default_nettype wire

// File: source/rom_loader_defs.svh
//********************
// iNES loader constants; sizes assume 22-bit offsets and a 32-bit AXI4-Lite bus
//********************
`ifndef ROM_LOADER_DEFS_SVH
`define ROM_LOADER_DEFS_SVH

// Header layout
`define ROM_HDR_BYTES 16

// "NES" then EOF marker
`define ROM_MAGIC_0 8'h4E
`define ROM_MAGIC_1 8'h45
`define ROM_MAGIC_2 8'h53
`define ROM_MAGIC_3 8'h1A

// Page sizes as shifts
`define ROM_PRG_SHIFT 14 // 16 KB per PRG page
`define ROM_CHR_SHIFT 13 // 8 KB per CHR page

// Memory map
`define ROM_OFS_W    22
`define ROM_CHR_BASE 22'h200000 // CHR region starts at 2 MB

// AXI4-Lite bus widths
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32

`endif
